// File: src/serdes_test_pkg.sv
package serdes_test_pkg;

  // Lane layout.
  localparam int unsigned NUM_LANES = 4;                // Number of loopback lanes.

  localparam logic [3:0] LANE_WIDTH [NUM_LANES] = '{   // Word width per lane.
    4'd2,
    4'd4,
    4'd6,
    4'd8
  };

  // PRBS7 with polynomial x^7 + x^6 + 1.
  localparam int unsigned PRBS_ORDER = 7;               // Length of the LFSR.
  localparam logic [PRBS_ORDER-1:0] PRBS_SEED = 7'h5b;  // Any nonzero start value.

  // Control timing.
  localparam int unsigned RST_STRETCH = 4;              // Restart hold after release.
  localparam logic [4:0] LOCK_COUNT = 5'd16;            // Good words needed for lock.
  localparam int unsigned HEARTBEAT_BIT = 23;           // Counter bit that blinks LED 4.

  // Per-lane result as seen by the control block and the pins.
  typedef struct packed {
    logic locked;  // Enough good words in a row.
    logic error;   // Bad word seen after lock.
  } lane_status_t;

endpackage

// File: src/test_ctrl.sv
module test_ctrl
  import serdes_test_pkg::*;
(
  input  logic                           CLK,
  input  logic                           arst_n,
  input  logic                           sw,
  input  lane_status_t [NUM_LANES-1:0]   status,
  output logic                           lane_rst,
  output logic [4:0]                     led
);

  logic [RST_STRETCH-1:0] rst_sr;     // Ones drain out of the bottom.
  logic [HEARTBEAT_BIT:0] hb_cnt;     // Free running.

  // Reset stretcher. A high sw reloads it, like a fresh power-up.
  always_ff @(posedge CLK or negedge arst_n) begin
    if (!arst_n) begin
      rst_sr <= '1;
    end else if (sw) begin
      rst_sr <= '1;
    end else begin
      rst_sr <= rst_sr >> 1;
    end
  end

  assign lane_rst = rst_sr[0];        // Held until the last one shifts out.

  always_ff @(posedge CLK or negedge arst_n) begin
    if (!arst_n) begin
      hb_cnt <= '0;
    end else begin
      hb_cnt <= hb_cnt + 1'b1;
    end
  end

  // A lane LED is lit only for a clean lock.
  always_comb begin
    for (int i = 0; i < NUM_LANES; i++) begin
      led[i] = status[i].locked & ~status[i].error;
    end
    led[4] = hb_cnt[HEARTBEAT_BIT];   // Heartbeat.
  end

  // The restart must reach the lanes one cycle after the switch.
  a_sw_restarts: assert property (
    @(posedge CLK) disable iff (!arst_n)
    sw |=> lane_rst
  );

endmodule

// File: src/prbs_word_gen.sv
module prbs_word_gen
  import serdes_test_pkg::*;
#(
  parameter int unsigned data_width = 8
)
(
  input  logic                  CLK,
  input  logic                  arst_n,
  input  logic                  lane_rst,
  input  logic                  word_stb,
  output logic [data_width-1:0] word
);

  logic [PRBS_ORDER-1:0] lfsr_q;      // Oldest bit at the top.
  logic [PRBS_ORDER-1:0] lfsr_nxt;    // State after one full word.

  // Run the LFSR data_width steps ahead. Bit k of the word is the
  // k-th bit produced, so LSB-first shifting keeps the stream intact.
  always_comb begin
    lfsr_nxt = lfsr_q;
    for (int k = 0; k < data_width; k++) begin
      word[k]  = lfsr_nxt[PRBS_ORDER-1] ^ lfsr_nxt[PRBS_ORDER-2];
      lfsr_nxt = {lfsr_nxt[PRBS_ORDER-2:0], word[k]};
    end
  end

  always_ff @(posedge CLK or negedge arst_n) begin
    if (!arst_n) begin
      lfsr_q <= PRBS_SEED;
    end else if (lane_rst) begin
      lfsr_q <= PRBS_SEED;            // Restart the sequence.
    end else if (word_stb) begin
      lfsr_q <= lfsr_nxt;             // Word is taken, move on.
    end
  end

endmodule

// File: src/word_serializer.sv
module word_serializer
  import serdes_test_pkg::*;
#(
  parameter int unsigned data_width = 8
)
(
  input  logic                  CLK,
  input  logic                  arst_n,
  input  logic                  lane_rst,
  input  logic                  word_stb,
  input  logic [data_width-1:0] word,
  output logic                  ser
);

  logic [data_width-1:0] shift_q;     // Bits still to be sent.

  always_ff @(posedge CLK or negedge arst_n) begin
    if (!arst_n) begin
      shift_q <= '0;
      ser     <= 1'b0;
    end else if (lane_rst) begin
      shift_q <= '0;
      ser     <= 1'b0;                // Line idles low.
    end else begin
      if (word_stb) begin
        shift_q <= word;
      end else begin
        shift_q <= shift_q >> 1;      // LSB first.
      end
      ser <= shift_q[0];
    end
  end

  // A new word before the old one is out would drop bits.
  a_stb_spacing: assert property (
    @(posedge CLK) disable iff (!arst_n || lane_rst)
    word_stb |=> !word_stb [* data_width-1]
  );

endmodule

// File: src/prbs_word_checker.sv
module prbs_word_checker
  import serdes_test_pkg::*;
#(
  parameter int unsigned data_width = 8
)
(
  input  logic         CLK,
  input  logic         arst_n,
  input  logic         lane_rst,
  input  logic         ser,
  output lane_status_t status
);

  localparam int unsigned BW = (data_width > 1) ? $clog2(data_width) : 1;

  logic [PRBS_ORDER-1:0] hist_q;      // Received bits, oldest at the top.
  logic [BW-1:0]         bit_cnt;     // Position inside the current word.
  logic                  acc_bad;     // Some earlier bit of this word was wrong.
  logic [4:0]            good_cnt;    // Good words in a row.
  logic                  bit_bad;
  logic                  word_end;
  logic                  word_bad;

  // Each bit must equal the XOR of the bits 7 and 6 places back.
  // An all-zero history is flagged too, else a dead line would pass.
  assign bit_bad  = (ser != (hist_q[PRBS_ORDER-1] ^ hist_q[PRBS_ORDER-2])) ||
                    (hist_q == '0);
  assign word_end = (bit_cnt == BW'(data_width - 1));
  assign word_bad = acc_bad | bit_bad;

  // Bit history and word framing.
  always_ff @(posedge CLK or negedge arst_n) begin
    if (!arst_n) begin
      hist_q  <= '0;
      bit_cnt <= '0;
      acc_bad <= 1'b0;
    end else if (lane_rst) begin
      hist_q  <= '0;
      bit_cnt <= '0;
      acc_bad <= 1'b0;
    end else begin
      hist_q <= {hist_q[PRBS_ORDER-2:0], ser};
      if (word_end) begin
        bit_cnt <= '0;
        acc_bad <= 1'b0;              // Fresh word.
      end else begin
        bit_cnt <= bit_cnt + 1'b1;
        acc_bad <= word_bad;
      end
    end
  end

  // Good word counter, lock and sticky error.
  always_ff @(posedge CLK or negedge arst_n) begin
    if (!arst_n) begin
      good_cnt      <= '0;
      status.locked <= 1'b0;
      status.error  <= 1'b0;
    end else if (lane_rst) begin
      good_cnt      <= '0;
      status.locked <= 1'b0;
      status.error  <= 1'b0;
    end else if (word_end) begin
      if (word_bad) begin
        good_cnt <= '0;
        if (status.locked) begin
          status.error <= 1'b1;       // Only counts once locked.
        end
      end else if (good_cnt != LOCK_COUNT) begin
        good_cnt <= good_cnt + 1'b1;  // Saturates at LOCK_COUNT.
        if (good_cnt == LOCK_COUNT - 1'b1) begin
          status.locked <= 1'b1;
        end
      end
    end
  end

  a_error_needs_lock: assert property (
    @(posedge CLK) disable iff (!arst_n)
    status.error |-> status.locked
  );

endmodule

// File: src/serdes_lane.sv
module serdes_lane
  import serdes_test_pkg::*;
#(
  parameter int unsigned data_width = 8
)
(
  input  logic         CLK,
  input  logic         arst_n,
  input  logic         lane_rst,
  input  logic         rx,
  output logic         tx,
  output lane_status_t status
);

  localparam int unsigned TW = (data_width > 1) ? $clog2(data_width) : 1;

  logic [TW-1:0]         tmr_cnt;     // Cycles into the current word.
  logic                  word_stb;
  logic [data_width-1:0] word;

  // Word timer. Sits at zero during restart, so the first strobe
  // falls in the first cycle after lane_rst drops.
  always_ff @(posedge CLK or negedge arst_n) begin
    if (!arst_n) begin
      tmr_cnt <= '0;
    end else if (lane_rst || (tmr_cnt == TW'(data_width - 1))) begin
      tmr_cnt <= '0;
    end else begin
      tmr_cnt <= tmr_cnt + 1'b1;
    end
  end

  assign word_stb = (tmr_cnt == '0) && !lane_rst;

  prbs_word_gen #(.data_width(data_width)) i_gen (
    .CLK      (CLK),
    .arst_n   (arst_n),
    .lane_rst (lane_rst),
    .word_stb (word_stb),
    .word     (word)
  );

  word_serializer #(.data_width(data_width)) i_ser (
    .CLK      (CLK),
    .arst_n   (arst_n),
    .lane_rst (lane_rst),
    .word_stb (word_stb),
    .word     (word),
    .ser      (tx)
  );

  prbs_word_checker #(.data_width(data_width)) i_chk (
    .CLK      (CLK),
    .arst_n   (arst_n),
    .lane_rst (lane_rst),
    .ser      (rx),
    .status   (status)
  );

endmodule

// File: src/serdes_test_top.sv
module serdes_test_top
  import serdes_test_pkg::*;
(
  input  logic                         CLK,
  input  logic                         arst_n,
  input  logic                         sw,
  input  logic [NUM_LANES-1:0]         in,
  output logic [NUM_LANES-1:0]         out,
  output logic [4:0]                   led,
  output lane_status_t [NUM_LANES-1:0] status
);

  logic lane_rst;                     // Shared synchronous restart.

  test_ctrl i_ctrl (
    .CLK      (CLK),
    .arst_n   (arst_n),
    .sw       (sw),
    .status   (status),
    .lane_rst (lane_rst),
    .led      (led)
  );

  // One lane per entry of the width table.
  for (genvar i = 0; i < NUM_LANES; i++) begin : g_lane
    serdes_lane #(.data_width(LANE_WIDTH[i])) i_lane (
      .CLK      (CLK),
      .arst_n   (arst_n),
      .lane_rst (lane_rst),
      .rx       (in[i]),
      .tx       (out[i]),
      .status   (status[i])
    );
  end

endmodule

// File: dv/serdes_test_tb.sv
module serdes_test_tb
  import serdes_test_pkg::*;
();

  localparam int LOCK_TMO = 200;              // Cycles allowed for a lane to lock.
  localparam int SW_TMO   = RST_STRETCH + 1;  // Cycles allowed for a restart to clear.
  localparam int NUM_ROWS = 11;

  localparam logic [1:0] TBL  = 2'd0;         // Delays come from the row.
  localparam logic [1:0] RND  = 2'd1;         // Delays come from the LFSR.
  localparam logic [1:0] KEEP = 2'd2;         // Delays stay as they are.

  // One step of the test sequence.
  typedef struct packed {
    logic [1:0]                dly_mode;
    logic [NUM_LANES-1:0][2:0] dly;           // Loopback delay per lane.
    logic [NUM_LANES-1:0]      stuck;         // Lanes forced to 0.
    logic                      sw;
    logic                      rnd_flip;      // Flip one random lane.
    logic [NUM_LANES-1:0]      flip;          // Lanes that get one inverted bit.
    logic [NUM_LANES-1:0]      exp_lock;
    logic [NUM_LANES-1:0]      exp_err;
    int                        limit;         // Cycles to reach the expected state.
    int                        hold;          // Cycles the state must then hold.
  } row_t;

  logic                         CLK = 1'b0;
  logic                         arst_n;
  logic                         sw;
  logic [NUM_LANES-1:0]         in;
  logic [NUM_LANES-1:0]         out;
  logic [4:0]                   led;
  lane_status_t [NUM_LANES-1:0] status;

  logic [NUM_LANES-1:0][2:0]    cur_dly;
  logic [NUM_LANES-1:0]         stuck_mask;
  logic [NUM_LANES-1:0]         flip_mask;
  logic [NUM_LANES-1:0][7:0]    line_q;       // Past out values, newest in bit 0.
  logic [16:0]                  lfsr_q;
  row_t                         rows [NUM_ROWS];

  always #2 CLK = ~CLK;

  serdes_test_top i_dut (
    .CLK    (CLK),
    .arst_n (arst_n),
    .sw     (sw),
    .in     (in),
    .out    (out),
    .led    (led),
    .status (status)
  );

  // Loopback with delay, stuck lanes and bit flips. Runs after the
  // main stimulus so the masks are settled when they are read.
  initial begin
    in     = '0;
    line_q = '0;
    forever begin
      @(posedge CLK);
      #2;
      for (int i = 0; i < NUM_LANES; i++) begin
        line_q[i] = {line_q[i][6:0], out[i]};
        in[i]     = (line_q[i][cur_dly[i]] & ~stuck_mask[i]) ^ flip_mask[i];
      end
    end
  end

  // Fibonacci LFSR, x^17 + x^14 + 1.
  function automatic logic [16:0] lfsr_next(input logic [16:0] s);
    return {s[15:0], s[16] ^ s[13]};
  endfunction

  task automatic take_bits(input int n, output logic [7:0] val);
    val = '0;
    for (int k = 0; k < n; k++) begin
      lfsr_q = lfsr_next(lfsr_q);
      val    = {val[6:0], lfsr_q[0]};             // One step per bit.
    end
  endtask

  function automatic logic [NUM_LANES-1:0] locked_bits();
    logic [NUM_LANES-1:0] v;
    for (int i = 0; i < NUM_LANES; i++) begin
      v[i] = status[i].locked;
    end
    return v;
  endfunction

  function automatic logic [NUM_LANES-1:0] error_bits();
    logic [NUM_LANES-1:0] v;
    for (int i = 0; i < NUM_LANES; i++) begin
      v[i] = status[i].error;
    end
    return v;
  endfunction

  function automatic logic status_is(input logic [3:0] lk, input logic [3:0] er);
    return (locked_bits() == lk) && (error_bits() == er);
  endfunction

  task automatic compare(input logic [3:0] got, input logic [3:0] exp, input string what);
    if (got !== exp) begin
      $display("ERR %0t: %s is %b, expected %b", $time, what, got, exp);
      $display("Errors found");
      $fatal(1, "stopped at the first mismatch");
    end
  endtask

  task automatic check_outputs(input logic [3:0] lk, input logic [3:0] er, input logic idle);
    compare(locked_bits(), lk, "locked flags");
    compare(error_bits(), er, "error flags");
    compare(led[3:0], lk & ~er, "lane LEDs");     // Lit only for a clean lock.
    compare({3'b000, led[4]}, 4'b0000, "heartbeat LED");
    if (idle) begin
      compare(out, 4'b0000, "serial outputs");    // Lines idle low in restart.
    end
  endtask

  task automatic wait_for_status(input logic [3:0] lk, input logic [3:0] er, input int limit);
    int n;
    n = 0;
    while (!status_is(lk, er) && (n < limit)) begin
      @(posedge CLK);
      #1;
      n++;
    end
    if (!status_is(lk, er)) begin
      $display("lanes did not reach the expected lock and error state before timeout");
      $display("Errors found");
      $fatal(1, "wait for lane status timed out");
    end
  endtask

  task automatic hold_status(input logic [3:0] lk, input logic [3:0] er, input logic idle,
                             input int cycles);
    for (int n = 0; n < cycles; n++) begin
      @(posedge CLK);
      #1;
      check_outputs(lk, er, idle);
    end
  endtask

  task automatic inject_flip(input logic [NUM_LANES-1:0] lanes);
    flip_mask = lanes;
    @(posedge CLK);
    #1;
    flip_mask = '0;                                 // One cycle only.
  endtask

  task automatic apply_row(input row_t r);
    logic [7:0]           pick;
    logic [NUM_LANES-1:0] flips;
    logic [NUM_LANES-1:0] exp_err;
    exp_err = r.exp_err;
    flips   = r.flip;
    if (r.dly_mode == TBL) begin
      cur_dly = r.dly;
    end else if (r.dly_mode == RND) begin
      for (int i = 0; i < NUM_LANES; i++) begin
        take_bits(3, pick);
        cur_dly[i] = pick[2:0];
      end
    end
    stuck_mask = r.stuck;
    sw         = r.sw;
    if (r.rnd_flip) begin
      take_bits(2, pick);
      flips   = 4'b0001 << pick[1:0];
      exp_err = flips;                              // Only the hit lane reports.
    end
    if (flips != '0) begin
      inject_flip(flips);
    end
    wait_for_status(r.exp_lock, exp_err, r.limit);
    check_outputs(r.exp_lock, exp_err, r.sw);
    hold_status(r.exp_lock, exp_err, r.sw, r.hold);
  endtask

  task automatic load_table();
    // mode  delays lane 3..0                   stuck    sw    rflip flip     lock     err
    rows[0]  = '{TBL,  {3'd3, 3'd2, 3'd1, 3'd0}, 4'b0000, 1'b0, 1'b0, 4'b0000, 4'b1111, 4'b0000,
                 LOCK_TMO, 100};
    rows[1]  = '{KEEP, 12'd0, 4'b0000, 1'b0, 1'b0, 4'b0100, 4'b1111, 4'b0100, LOCK_TMO, 20};
    rows[2]  = '{TBL,  {3'd7, 3'd6, 3'd5, 3'd4}, 4'b0000, 1'b1, 1'b0, 4'b0000, 4'b0000, 4'b0000,
                 SW_TMO, 10};
    rows[3]  = '{KEEP, 12'd0, 4'b0000, 1'b0, 1'b0, 4'b0000, 4'b1111, 4'b0000, LOCK_TMO, 100};
    rows[4]  = '{KEEP, 12'd0, 4'b0010, 1'b1, 1'b0, 4'b0000, 4'b0000, 4'b0000, SW_TMO, 10};
    rows[5]  = '{KEEP, 12'd0, 4'b0010, 1'b0, 1'b0, 4'b0000, 4'b1101, 4'b0000, LOCK_TMO, 200};
    rows[6]  = '{RND,  12'd0, 4'b0000, 1'b1, 1'b0, 4'b0000, 4'b0000, 4'b0000, SW_TMO, 10};
    rows[7]  = '{KEEP, 12'd0, 4'b0000, 1'b0, 1'b0, 4'b0000, 4'b1111, 4'b0000, LOCK_TMO, 50};
    rows[8]  = '{KEEP, 12'd0, 4'b0000, 1'b0, 1'b1, 4'b0000, 4'b1111, 4'b0000, LOCK_TMO, 20};
    rows[9]  = '{RND,  12'd0, 4'b0000, 1'b1, 1'b0, 4'b0000, 4'b0000, 4'b0000, SW_TMO, 10};
    rows[10] = '{KEEP, 12'd0, 4'b0000, 1'b0, 1'b0, 4'b0000, 4'b1111, 4'b0000, LOCK_TMO, 100};
  endtask

  initial begin
    arst_n     = 1'b0;
    sw         = 1'b0;
    cur_dly    = '0;
    stuck_mask = '0;
    flip_mask  = '0;
    lfsr_q     = 17'd99447;
    load_table();
    repeat (2) @(posedge CLK);
    #1;
    arst_n = 1'b1;
    for (int i = 0; i < NUM_ROWS; i++) begin
      apply_row(rows[i]);
    end
    $display("No errors");
    $finish;
  end

endmodule

// File: tb.f
src/serdes_test_pkg.sv
src/test_ctrl.sv
src/prbs_word_gen.sv
src/word_serializer.sv
src/prbs_word_checker.sv
src/serdes_lane.sv
src/serdes_test_top.sv
dv/serdes_test_tb.sv

// File: run_sim.sh
#!/bin/sh
# Build and run the testbench with Verilator; the log decides pass or fail.
cd "$(dirname "$0")" &&
verilator --binary --assert --top-module serdes_test_tb -f tb.f -o serdes_sim &&
./obj_dir/serdes_sim 2>&1 | tee sim.log &&
grep -qx "No errors" sim.log &&
echo "PASS" ||
{ echo "FAIL"; exit 1; }
